// File: hw/mem_pkg.sv
package mem_pkg;

    // ==================================================
    // Tile buffer geometry
    // ==================================================

    // Word width in bits
    localparam int DATA_BIT = 32;
    // Words per tile, one tile per bank
    localparam int DEPTH    = 16;
    localparam int ADDR_BIT = 4;
    // Byte lanes per word
    localparam int MASK_BIT = 4;

    // Data word as stored in a bank
    typedef logic [DATA_BIT-1:0] word_t;

endpackage

// File: hw/ctrl_pkg.sv
package ctrl_pkg;

    // ==================================================
    // Host command opcodes
    // ==================================================

    typedef enum logic [1:0] {
        OP_WRITE      = 2'd0,   // whole word
        OP_WRITE_MASK = 2'd1,   // byte lanes from cmd_mask
        OP_COMMIT     = 2'd2    // end of tile, swap banks
    } cmd_op_e;

    // ==================================================
    // Control FSM states
    // ==================================================

    // Loader
    typedef enum logic [1:0] {LD_IDLE, LD_WAIT_GRANT, LD_ACK} ld_state_e;

    // Reducer
    typedef enum logic [2:0] {RD_IDLE, RD_SCAN, RD_DRAIN, RD_REQ, RD_RELEASE} rd_state_e;

    // Ping-pong controller, read bank free or busy
    typedef enum logic {PP_FREE, PP_BUSY} pp_state_e;

endpackage

// File: hw/buffer_ifs.sv
`timescale 1ns/10ps

// Bank access, one write port and one read port on the double buffer
interface bank_if import mem_pkg::*;
();
    // Write side, always the bank not being read
    logic [ADDR_BIT-1:0] waddr;
    logic                wen;
    word_t               wdata;
    word_t               bwe;
    // Read side
    logic [ADDR_BIT-1:0] raddr;
    logic                ren;
    word_t               rdata;

    modport writer  (output waddr, wen, wdata, bwe);
    modport reader  (output raddr, ren, input rdata);
    modport mem     (input waddr, wen, wdata, bwe, raddr, ren, output rdata);
endinterface

// Swap control between loader, controller and reducer
interface swap_if;
    // Level, held by the loader until grant
    logic commit;
    // One-cycle pulses
    logic grant;
    logic start;
    logic done;

    modport loader  (output commit, input grant);
    modport ctrl    (input commit, done, output grant, start);
    modport reducer (input start, output done);
endinterface

// File: hw/mem_sp.sv
`timescale 1ns/10ps

module mem_sp import mem_pkg::*; (
    input  logic                clk,
    input  logic [ADDR_BIT-1:0] addr,
    input  logic                wen,
    input  word_t               bwe,
    input  word_t               wdata,
    input  logic                ren,
    output word_t               rdata
);

    // Storage array, contents undefined until written
    word_t mem [DEPTH];

    // Write port
    // Bits under bwe take wdata, the rest keep the stored value
    always_ff @(posedge clk) begin
        if (wen) begin
            mem[addr] <= (wdata & bwe) | (mem[addr] & ~bwe);
        end
    end

    // Read port, one cycle latency
    always_ff @(posedge clk) begin
        if (ren) begin
            rdata <= mem[addr];
        end
    end

endmodule

// File: hw/mem_db.sv
`timescale 1ns/10ps

module mem_db import mem_pkg::*; (
    input  logic clk,
    input  logic arst_n,
    input  logic sw,
    bank_if.mem  bank
);

    logic [ADDR_BIT-1:0] bank0_addr;
    logic                bank0_wen;
    logic                bank0_ren;
    word_t               bank0_rdata;

    logic [ADDR_BIT-1:0] bank1_addr;
    logic                bank1_wen;
    logic                bank1_ren;
    word_t               bank1_rdata;

    // Bank that was read on the previous cycle
    logic                read_sw;

    // ==================================================
    // Banks
    // ==================================================

    mem_sp bank0 (
        .clk   (clk),
        .addr  (bank0_addr),
        .wen   (bank0_wen),
        .bwe   (bank.bwe),
        .wdata (bank.wdata),
        .ren   (bank0_ren),
        .rdata (bank0_rdata)
    );

    mem_sp bank1 (
        .clk   (clk),
        .addr  (bank1_addr),
        .wen   (bank1_wen),
        .bwe   (bank.bwe),
        .wdata (bank.wdata),
        .ren   (bank1_ren),
        .rdata (bank1_rdata)
    );

    // ==================================================
    // Bank multiplexer
    // ==================================================

    // sw high: write bank0, read bank1
    // sw low: write bank1, read bank0
    always_comb begin
        bank0_addr = sw ? bank.waddr : bank.raddr;
        bank0_wen  = sw & bank.wen;
        bank0_ren  = ~sw & bank.ren;
        bank1_addr = sw ? bank.raddr : bank.waddr;
        bank1_wen  = ~sw & bank.wen;
        bank1_ren  = sw & bank.ren;
    end

    // Read data follows the bank selected at ren time
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            read_sw <= 1'b0;
        end else begin
            read_sw <= sw;
        end
    end

    assign bank.rdata = read_sw ? bank1_rdata : bank0_rdata;

endmodule

// File: hw/tile_loader.sv
`timescale 1ns/10ps

module tile_loader import mem_pkg::*, ctrl_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                cmd_req,
    input  cmd_op_e             cmd_op,
    input  logic [ADDR_BIT-1:0] cmd_addr,
    input  word_t               cmd_data,
    input  logic [MASK_BIT-1:0] cmd_mask,
    output logic                cmd_ack,
    bank_if.writer              wr,
    swap_if.loader              sw_ctl
);

    ld_state_e state;
    logic      is_write;

    assign is_write = (cmd_op == OP_WRITE) || (cmd_op == OP_WRITE_MASK);

    // Host handshake FSM
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= LD_IDLE;
        end else begin
            case (state)
                LD_IDLE: begin
                    if (cmd_req) begin
                        // Writes land this cycle, commits wait for the swap
                        state <= (cmd_op == OP_COMMIT) ? LD_WAIT_GRANT : LD_ACK;
                    end
                end
                LD_WAIT_GRANT: if (sw_ctl.grant) state <= LD_ACK;
                // Hold ack until the host drops req
                LD_ACK:        if (!cmd_req) state <= LD_IDLE;
                default:       state <= LD_IDLE;
            endcase
        end
    end

    assign cmd_ack       = (state == LD_ACK);
    assign sw_ctl.commit = (state == LD_WAIT_GRANT);

    // Bank write, fields are stable while req is high
    assign wr.wen   = (state == LD_IDLE) && cmd_req && is_write;
    assign wr.waddr = cmd_addr;
    assign wr.wdata = cmd_data;

    // Expand each mask bit into a byte lane
    always_comb begin
        for (int i = 0; i < MASK_BIT; i++) begin
            wr.bwe[i*(DATA_BIT/MASK_BIT) +: DATA_BIT/MASK_BIT] =
                {(DATA_BIT/MASK_BIT){cmd_mask[i] || (cmd_op == OP_WRITE)}};
        end
    end

endmodule

// File: hw/pingpong_ctrl.sv
`timescale 1ns/10ps

module pingpong_ctrl import ctrl_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    swap_if.ctrl  sw_ctl,
    output logic  sw
);

    pp_state_e state;
    logic      reader_free;

    // ==================================================
    // Swap arbitration
    // ==================================================

    // Read bank can be handed over when idle or in its done cycle
    assign reader_free = (state == PP_FREE) || sw_ctl.done;

    assign sw_ctl.grant = sw_ctl.commit && reader_free;
    // New read bank goes straight to the reducer
    assign sw_ctl.start = sw_ctl.grant;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= PP_FREE;
            sw    <= 1'b0;
        end else begin
            if (sw_ctl.grant) begin
                // Swap banks on the grant edge
                sw    <= ~sw;
                state <= PP_BUSY;
            end else if (sw_ctl.done) begin
                state <= PP_FREE;
            end
        end
    end

endmodule

// File: hw/tile_reducer.sv
`timescale 1ns/10ps

module tile_reducer import mem_pkg::*, ctrl_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    bank_if.reader rd,
    swap_if.reducer sw_ctl,
    output logic   res_req,
    input  logic   res_ack,
    output word_t  res_sum
);

    rd_state_e           state;
    logic [ADDR_BIT-1:0] cnt;
    // Marks rdata valid, one cycle behind ren
    logic                rd_vld;
    word_t               sum;

    // ==================================================
    // Scan and result FSM
    // ==================================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= RD_IDLE;
            cnt    <= '0;
            rd_vld <= 1'b0;
        end else begin
            rd_vld <= rd.ren;
            case (state)
                RD_IDLE: begin
                    cnt <= '0;
                    if (sw_ctl.start) state <= RD_SCAN;
                end
                RD_SCAN: begin
                    cnt <= cnt + 1'b1;
                    // Last address of the tile
                    if (cnt == ADDR_BIT'(DEPTH - 1)) state <= RD_DRAIN;
                end
                // Last word returns here
                RD_DRAIN: state <= RD_REQ;
                RD_REQ:   if (res_ack) state <= RD_RELEASE;
                RD_RELEASE: begin
                    cnt <= '0;
                    // Next tile may start in the done cycle
                    if (!res_ack) state <= sw_ctl.start ? RD_SCAN : RD_IDLE;
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // Accumulator, cleared when a tile starts
    always_ff @(posedge clk) begin
        if (sw_ctl.start) begin
            sum <= '0;
        end else if (rd_vld) begin
            sum <= sum + rd.rdata;   // wraps at 32 bits
        end
    end

    assign rd.ren      = (state == RD_SCAN);
    assign rd.raddr    = cnt;
    assign res_req     = (state == RD_REQ);
    assign res_sum     = sum;
    assign sw_ctl.done = (state == RD_RELEASE) && !res_ack;

endmodule

// File: hw/tile_buffer_top.sv
`timescale 1ns/10ps

module tile_buffer_top import mem_pkg::*, ctrl_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    // Host command channel
    input  logic                cmd_req,
    input  cmd_op_e             cmd_op,
    input  logic [ADDR_BIT-1:0] cmd_addr,
    input  word_t               cmd_data,
    input  logic [MASK_BIT-1:0] cmd_mask,
    output logic                cmd_ack,
    // Result channel
    output logic                res_req,
    output word_t               res_sum,
    input  logic                res_ack
);

    logic sw;

    bank_if bank_i ();
    swap_if swap_i ();

    // ==================================================
    // Datapath and control
    // ==================================================

    mem_db mem_db_i (
        .clk    (clk),
        .arst_n (arst_n),
        .sw     (sw),
        .bank   (bank_i.mem)
    );

    tile_loader loader_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .cmd_req  (cmd_req),
        .cmd_op   (cmd_op),
        .cmd_addr (cmd_addr),
        .cmd_data (cmd_data),
        .cmd_mask (cmd_mask),
        .cmd_ack  (cmd_ack),
        .wr       (bank_i.writer),
        .sw_ctl   (swap_i.loader)
    );

    pingpong_ctrl ctrl_i (
        .clk    (clk),
        .arst_n (arst_n),
        .sw_ctl (swap_i.ctrl),
        .sw     (sw)
    );

    tile_reducer reducer_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .rd      (bank_i.reader),
        .sw_ctl  (swap_i.reducer),
        .res_req (res_req),
        .res_ack (res_ack),
        .res_sum (res_sum)
    );

endmodule

// File: bench/tb_clkgen.sv
`timescale 1ns/10ps

// Free-running clock, 40 ns period
module tb_clkgen (
    output logic clk
);

    // Half period in ns
    localparam int HALF_PERIOD = 20;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

// File: bench/tb_assertions.sv
`timescale 1ns/10ps

// Four-phase rules on the host command and result channels
module tb_assertions
    import mem_pkg::*;
(
    input logic  clk,
    input logic  arst_n,
    input logic  cmd_req,
    input logic  cmd_ack,
    input logic  res_req,
    input logic  res_ack,
    input word_t res_sum
);

    // ==================================================
    // Command channel
    // ==================================================

    // Ack only answers a pending request
    cmd_ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(cmd_ack) |-> $past(cmd_req))
        else $error("cmd_ack rose without cmd_req");

    // Ack held until the host lets go of req
    cmd_ack_held: assert property (@(posedge clk) disable iff (!arst_n)
        cmd_ack && cmd_req |=> cmd_ack)
        else $error("cmd_ack fell while cmd_req was still high");

    // ==================================================
    // Result channel
    // ==================================================

    res_ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(res_ack) |-> res_req)
        else $error("res_ack rose without res_req");

    // Request held until answered
    res_req_held: assert property (@(posedge clk) disable iff (!arst_n)
        res_req && !res_ack |=> res_req)
        else $error("res_req fell before res_ack");

    // Sum frozen for the whole request
    res_sum_stable: assert property (@(posedge clk) disable iff (!arst_n)
        res_req && $past(res_req) |-> $stable(res_sum))
        else $error("res_sum changed while res_req was high");

endmodule

bind tile_buffer_top tb_assertions assert_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .cmd_req (cmd_req),
    .cmd_ack (cmd_ack),
    .res_req (res_req),
    .res_ack (res_ack),
    .res_sum (res_sum)
);

// File: bench/tb_top.sv
`timescale 1ns/10ps

module tb_top
    import mem_pkg::*, ctrl_pkg::*;
();

    // Wait limits in clock cycles
    localparam int CMD_LIMIT  = 300;
    localparam int RES_LIMIT  = 300;
    localparam int IDLE_LIMIT = 500;

    // One stimulus row
    typedef struct {
        cmd_op_e             op;
        logic [ADDR_BIT-1:0] addr;
        word_t               data;
        logic [MASK_BIT-1:0] mask;
        int                  ack_dly;   // cycles before res_ack
        bit                  use_lcg;   // data from the LCG
    } row_t;

    logic                clk;
    logic                arst_n;
    logic                cmd_req;
    cmd_op_e             cmd_op;
    logic [ADDR_BIT-1:0] cmd_addr;
    word_t               cmd_data;
    logic [MASK_BIT-1:0] cmd_mask;
    logic                cmd_ack;
    logic                res_req;
    word_t               res_sum;
    logic                res_ack;

    row_t  stim_rows[$];
    // Expected sums and ack delays per commit
    word_t exp_q[$];
    int    dly_q[$];

    // Reference model with two banks and the switch bit
    word_t model_bank[2][DEPTH];
    logic  model_sw;
    word_t lcg;

    int errors;
    int timeouts;
    int commits;
    int results_done;

    tb_clkgen clkgen_i (.clk(clk));

    tile_buffer_top dut_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .cmd_req  (cmd_req),
        .cmd_op   (cmd_op),
        .cmd_addr (cmd_addr),
        .cmd_data (cmd_data),
        .cmd_mask (cmd_mask),
        .cmd_ack  (cmd_ack),
        .res_req  (res_req),
        .res_sum  (res_sum),
        .res_ack  (res_ack)
    );

    // ==================================================
    // Helpers
    // ==================================================

    function automatic word_t lcg_next(word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Byte lanes touched by a write
    function automatic word_t lane_mask(cmd_op_e op, logic [MASK_BIT-1:0] mask);
        word_t m;
        m = '0;
        for (int b = 0; b < MASK_BIT; b++) begin
            m[b*8 +: 8] = (op == OP_WRITE || mask[b]) ? 8'hFF : 8'h00;
        end
        return m;
    endfunction

    function automatic void add_row(cmd_op_e op, logic [ADDR_BIT-1:0] addr, word_t data,
                                    logic [MASK_BIT-1:0] mask, int dly, bit use_lcg);
        row_t r;
        r.op      = op;
        r.addr    = addr;
        r.data    = data;
        r.mask    = mask;
        r.ack_dly = dly;
        r.use_lcg = use_lcg;
        stim_rows.push_back(r);
    endfunction

    // Whole tile of LCG words followed by its commit
    function automatic void add_tile(int dly);
        for (int a = 0; a < DEPTH; a++) begin
            add_row(OP_WRITE, ADDR_BIT'(a), '0, 4'hF, 0, 1'b1);
        end
        add_row(OP_COMMIT, '0, '0, '0, dly, 1'b0);
    endfunction

    function automatic void build_table();
        // Two full tiles
        add_tile(3);
        add_tile(0);
        // Partial rewrite of the first tile's bank with mixed masks
        add_row(OP_WRITE_MASK, 4'd0, 32'hA5A5_A5A5, 4'b0001, 0, 1'b0);
        add_row(OP_WRITE_MASK, 4'd3, 32'h1234_5678, 4'b1010, 0, 1'b0);
        add_row(OP_WRITE_MASK, 4'd7, '0, 4'b1100, 0, 1'b1);
        add_row(OP_WRITE, 4'd9, 32'h0BAD_F00D, 4'b0000, 0, 1'b0);
        add_row(OP_WRITE_MASK, 4'd15, 32'h8000_0001, 4'b1001, 0, 1'b0);
        // Empty mask leaves the word alone
        add_row(OP_WRITE_MASK, 4'd12, 32'hDEAD_BEEF, 4'b0000, 0, 1'b0);
        add_row(OP_COMMIT, '0, '0, '0, 2, 1'b0);
        // Five commits with some back to back
        add_row(OP_WRITE, 4'd5, '0, 4'hF, 0, 1'b1);
        add_row(OP_COMMIT, '0, '0, '0, 1, 1'b0);
        add_row(OP_COMMIT, '0, '0, '0, 0, 1'b0);
        add_row(OP_WRITE_MASK, 4'd2, '0, 4'b0110, 0, 1'b1);
        add_row(OP_COMMIT, '0, '0, '0, 4, 1'b0);
        add_row(OP_COMMIT, '0, '0, '0, 0, 1'b0);
        add_row(OP_COMMIT, '0, '0, '0, 1, 1'b0);
        // Result held off while the next tile loads
        add_row(OP_COMMIT, '0, '0, '0, 60, 1'b0);
        add_tile(1);
    endfunction

    task automatic check(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %08h expected %08h", $time, what, got, exp);
        end
    endtask

    // Four-phase command issued and finished 2 ns after an edge
    task automatic send_cmd(input cmd_op_e op, input logic [ADDR_BIT-1:0] addr,
                            input word_t data, input logic [MASK_BIT-1:0] mask);
        int n;
        cmd_op   = op;
        cmd_addr = addr;
        cmd_data = data;
        cmd_mask = mask;
        cmd_req  = 1'b1;
        n = 0;
        while (!cmd_ack && n < CMD_LIMIT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!cmd_ack) begin
            timeouts++;
            $display("Timeout: no cmd_ack for %s at %0t", op.name(), $time);
        end else if (op != OP_COMMIT) begin
            // Writes are acknowledged on the first edge even under back-pressure
            check("write ack latency", word_t'(n), word_t'(1));
        end
        cmd_req = 1'b0;
        n = 0;
        while (cmd_ack && n < CMD_LIMIT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (cmd_ack) begin
            timeouts++;
            $display("Timeout: cmd_ack stayed high after cmd_req fell at %0t", $time);
        end
    endtask

    // ==================================================
    // Stimulus and reference model
    // ==================================================

    initial begin : stimulus
        row_t  r;
        word_t d;
        word_t m;
        word_t s;
        int    wb;
        int    rb;
        int    n;
        cmd_req      = 1'b0;
        cmd_op       = OP_WRITE;
        cmd_addr     = '0;
        cmd_data     = '0;
        cmd_mask     = '0;
        arst_n       = 1'b0;
        model_sw     = 1'b0;
        lcg          = 32'd19;
        errors       = 0;
        timeouts     = 0;
        commits      = 0;
        results_done = 0;
        build_table();
        repeat (16) @(posedge clk);
        #2;
        arst_n = 1'b1;

        for (int i = 0; i < stim_rows.size(); i++) begin
            r = stim_rows[i];
            d = r.data;
            if (r.use_lcg) begin
                lcg = lcg_next(lcg);
                d   = lcg;
            end
            if (r.op == OP_COMMIT) begin
                // Swap and sum the bank that becomes the read bank
                model_sw = ~model_sw;
                rb = model_sw ? 1 : 0;
                s = '0;
                for (int k = 0; k < DEPTH; k++) begin
                    s = s + model_bank[rb][k];
                end
                exp_q.push_back(s);
                dly_q.push_back(r.ack_dly);
                commits++;
                send_cmd(r.op, r.addr, d, r.mask);
                // Grant only after the previous result is released
                check("results released at commit ack", word_t'(results_done),
                      word_t'(commits - 1));
            end else begin
                m  = lane_mask(r.op, r.mask);
                wb = model_sw ? 0 : 1;
                model_bank[wb][r.addr] = (d & m) | (model_bank[wb][r.addr] & ~m);
                send_cmd(r.op, r.addr, d, r.mask);
            end
        end

        n = 0;
        while (results_done != commits && n < RES_LIMIT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (results_done != commits) begin
            timeouts++;
            $display("Timeout: only %0d of %0d results came back", results_done, commits);
        end
        $display("Done: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // ==================================================
    // Result channel responder
    // ==================================================

    initial begin : result_responder
        word_t exp_sum;
        int    dly;
        int    n;
        res_ack = 1'b0;
        forever begin
            n = 0;
            while (exp_q.size() == 0 && n < IDLE_LIMIT) begin
                @(posedge clk);
                #2;
                n++;
            end
            if (exp_q.size() == 0) begin
                timeouts++;
                $display("Timeout: result channel idle for %0d cycles", IDLE_LIMIT);
            end else begin
                exp_sum = exp_q.pop_front();
                dly     = dly_q.pop_front();
                n = 0;
                while (!res_req && n < RES_LIMIT) begin
                    @(posedge clk);
                    #2;
                    n++;
                end
                if (!res_req) begin
                    timeouts++;
                    $display("Timeout: no res_req for a committed tile at %0t", $time);
                end else begin
                    check("res_sum", res_sum, exp_sum);
                    // Back-pressure from the row
                    for (int k = 0; k < dly; k++) begin
                        @(posedge clk);
                        #2;
                    end
                    res_ack = 1'b1;
                    n = 0;
                    while (res_req && n < RES_LIMIT) begin
                        @(posedge clk);
                        #2;
                        n++;
                    end
                    if (res_req) begin
                        timeouts++;
                        $display("Timeout: res_req stayed high after res_ack at %0t", $time);
                    end
                    res_ack = 1'b0;
                    results_done++;
                end
            end
        end
    end

endmodule

// File: src.f
hw/mem_pkg.sv
hw/ctrl_pkg.sv
hw/buffer_ifs.sv
hw/mem_sp.sv
hw/mem_db.sv
hw/tile_loader.sv
hw/pingpong_ctrl.sv
hw/tile_reducer.sv
hw/tile_buffer_top.sv
bench/tb_clkgen.sv
bench/tb_assertions.sv
bench/tb_top.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = tb_top
FLIST = src.f
BUILD = obj_dir
LOG   = sim.log
FAIL  = Simulation FAILED

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL)" $(LOG); then \
		echo "sim: run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
